// File: cart_settings.svh
`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

// word address width of the cartridge store, so the store holds 1024 words.
`define CART_ADDR_W 10

// number of register slots decoded in the configuration region.
`define CART_REG_COUNT 4

// longest wait from req to ack that the handshake checks accept.
`define CART_ACK_TIMEOUT 16

`endif

// File: cart_pkg.sv
`include "cart_settings.svh"

package cart_pkg;

    // one access to the word store, shared by both requesters.
    typedef struct packed {
        logic [`CART_ADDR_W-1:0] addr;
        logic [15:0]             wdata;
        logic                    write;
    } mem_req_t;

    typedef struct packed {
        logic [15:0] rdata;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        set_addr   = 2'd0,
        write_data = 2'd1,
        notify     = 2'd2
    } host_op_e;

    typedef struct packed {
        host_op_e    op;
        logic [15:0] payload;
    } host_cmd_t;

    // bit 31 selects the region: 0 is memory, 1 is the configuration registers.
    typedef struct packed {
        logic                    region;
        logic [30-`CART_ADDR_W:0] unused;
        logic [`CART_ADDR_W-1:0] word;
    } pi_mem_view_t;

    typedef struct packed {
        logic        region;
        logic [28:0] unused;
        logic [1:0]  idx;
    } pi_reg_view_t;

    typedef union packed {
        pi_mem_view_t mem;
        pi_reg_view_t regs;
    } pi_addr_u;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [1:0]  idx;
        logic [15:0] wdata;
    } reg_bus_t;

endpackage

// File: cart_store.sv
`timescale 1ns/1ps
`include "cart_settings.svh"

module cart_store (
    input  logic               i_sys,
    input  logic               i_store_en,
    input  cart_pkg::mem_req_t i_store,
    output logic [15:0]        o_rdata
);

    logic [15:0] words [2**`CART_ADDR_W];

    // write-first, so a write returns the new word on the read port.
    always_ff @(posedge i_sys) begin
        if (i_store_en) begin
            if (i_store.write) begin
                words[i_store.addr] <= i_store.wdata;
                o_rdata             <= i_store.wdata;
            end else begin
                o_rdata <= words[i_store.addr];
            end
        end
    end

endmodule

// File: mem_arbiter.sv
`timescale 1ns/1ps
`include "cart_settings.svh"

module mem_arbiter (
    input  logic               i_sys,
    input  logic               i_reset,
    input  logic               i_req_a,
    input  cart_pkg::mem_req_t i_mem_a,
    output logic               o_ack_a,
    output cart_pkg::mem_rsp_t o_rsp_a,
    input  logic               i_req_b,
    input  cart_pkg::mem_req_t i_mem_b,
    output logic               o_ack_b,
    output cart_pkg::mem_rsp_t o_rsp_b,
    output logic               o_store_en,
    output cart_pkg::mem_req_t o_store,
    input  logic [15:0]        i_store_rdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_ack
    } state_e;

    state_e state;
    logic   owner_b;
    logic   prio_b;
    logic   pick_b;
    logic   owner_req;

    assign pick_b    = i_req_b && (!i_req_a || prio_b);
    assign owner_req = owner_b ? i_req_b : i_req_a;

    always_ff @(posedge i_sys) begin
        if (i_reset) begin
            state   <= st_idle;
            owner_b <= 1'b0;
            prio_b  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (i_req_a || i_req_b) begin
                        owner_b <= pick_b;
                        prio_b  <= !pick_b;
                        state   <= st_access;
                    end
                end
                st_access: begin
                    state <= st_ack;
                end
                default: begin
                    // the grant stays until the owner releases its request.
                    if (!owner_req) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    assign o_store_en = (state == st_access);
    assign o_store    = owner_b ? i_mem_b : i_mem_a;
    assign o_ack_a    = (state == st_ack) && !owner_b;
    assign o_ack_b    = (state == st_ack) && owner_b;

    always_comb begin
        o_rsp_a.rdata = o_ack_a ? i_store_rdata : 16'h0000;
        o_rsp_b.rdata = o_ack_b ? i_store_rdata : 16'h0000;
    end

    a_ack_a_bound: assert property (@(posedge i_sys) disable iff (i_reset)
        $rose(i_req_a) |-> ##[1:`CART_ACK_TIMEOUT] o_ack_a);

    a_ack_b_bound: assert property (@(posedge i_sys) disable iff (i_reset)
        $rose(i_req_b) |-> ##[1:`CART_ACK_TIMEOUT] o_ack_b);

endmodule

// File: cfg_regs.sv
`timescale 1ns/1ps
`include "cart_settings.svh"

module cfg_regs (
    input  logic               i_sys,
    input  logic               i_reset,
    input  cart_pkg::reg_bus_t i_reg,
    output logic [15:0]        o_reg_rdata,
    input  logic               i_notify,
    input  logic               i_loader_busy,
    output logic               o_n64_irq,
    output logic               o_led
);

    logic        irq_pending;
    logic        irq_enable;
    logic        led_on;
    logic [15:0] scratch;
    logic [15:0] rd_words [`CART_REG_COUNT];
    logic        wr_status;
    logic        wr_control;
    logic        wr_scratch;

    assign wr_status  = i_reg.valid && i_reg.write && (i_reg.idx == 2'd0);
    assign wr_control = i_reg.valid && i_reg.write && (i_reg.idx == 2'd1);
    assign wr_scratch = i_reg.valid && i_reg.write && (i_reg.idx == 2'd2);

    always_ff @(posedge i_sys) begin
        if (i_reset) begin
            irq_pending <= 1'b0;
            irq_enable  <= 1'b0;
            led_on      <= 1'b0;
        end else begin
            if (wr_control) begin
                irq_enable <= i_reg.wdata[0];
                led_on     <= i_reg.wdata[1];
            end
            // a notify in the same cycle as a clear keeps the interrupt pending.
            if (i_notify) begin
                irq_pending <= 1'b1;
            end else if (wr_status && i_reg.wdata[0]) begin
                irq_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_sys) begin
        if (wr_scratch) begin
            scratch <= i_reg.wdata;
        end
    end

    always_comb begin
        rd_words[0] = {14'd0, i_loader_busy, irq_pending};
        rd_words[1] = {14'd0, led_on, irq_enable};
        rd_words[2] = scratch;
        rd_words[3] = 16'h0000;
    end

    assign o_reg_rdata = rd_words[i_reg.idx];
    assign o_n64_irq   = irq_pending && irq_enable;
    assign o_led       = led_on;

endmodule

// File: host_loader.sv
`timescale 1ns/1ps
`include "cart_settings.svh"

module host_loader (
    input  logic                i_sys,
    input  logic                i_reset,
    input  logic                i_host_req,
    input  cart_pkg::host_cmd_t i_host_cmd,
    output logic                o_host_ack,
    output logic                o_mem_req,
    output cart_pkg::mem_req_t  o_mem,
    input  logic                i_mem_ack,
    output logic                o_notify,
    output logic                o_busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_write,
        st_ack
    } state_e;

    state_e                  state;
    logic [`CART_ADDR_W-1:0] wr_ptr;

    always_ff @(posedge i_sys) begin
        if (i_reset) begin
            state    <= st_idle;
            o_notify <= 1'b0;
        end else begin
            o_notify <= 1'b0;
            case (state)
                st_idle: begin
                    if (i_host_req) begin
                        case (i_host_cmd.op)
                            cart_pkg::write_data: begin
                                // wait until the previous memory ack has fallen.
                                if (!i_mem_ack) begin
                                    state <= st_write;
                                end
                            end
                            cart_pkg::notify: begin
                                o_notify <= 1'b1;
                                state    <= st_ack;
                            end
                            default: begin
                                state <= st_ack;
                            end
                        endcase
                    end
                end
                st_write: begin
                    if (i_mem_ack) begin
                        state <= st_ack;
                    end
                end
                default: begin
                    if (!i_host_req) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_sys) begin
        if (state == st_idle && i_host_req && i_host_cmd.op == cart_pkg::set_addr) begin
            wr_ptr <= i_host_cmd.payload[`CART_ADDR_W-1:0];
        end else if (state == st_write && i_mem_ack) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    assign o_host_ack = (state == st_ack);
    assign o_mem_req  = (state == st_write);
    assign o_busy     = (state != st_idle);

    always_comb begin
        o_mem.addr  = wr_ptr;
        o_mem.wdata = i_host_cmd.payload;
        o_mem.write = 1'b1;
    end

    // the payload feeds the store directly, so the host must hold it steady.
    a_cmd_stable: assert property (@(posedge i_sys) disable iff (i_reset)
        i_host_req && $past(i_host_req) |-> $stable(i_host_cmd));

endmodule

// File: pi_frontend.sv
`timescale 1ns/1ps

module pi_frontend (
    input  logic               i_sys,
    input  logic               i_reset,
    input  logic               i_pi_aleh,
    input  logic               i_pi_alel,
    input  logic               i_pi_read,
    input  logic               i_pi_write,
    input  logic [15:0]        i_pi_ad,
    output logic [15:0]        o_pi_rdata,
    output logic               o_pi_rvalid,
    output logic               o_pi_busy,
    output logic               o_mem_req,
    output cart_pkg::mem_req_t o_mem,
    input  logic               i_mem_ack,
    input  cart_pkg::mem_rsp_t i_mem_rsp,
    output cart_pkg::reg_bus_t o_reg,
    input  logic [15:0]        i_reg_rdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_release,
        st_done
    } state_e;

    state_e             state;
    cart_pkg::pi_addr_u addr_q;
    logic [15:0]        wdata_q;
    logic               is_write;
    logic               is_reg;
    logic               strobe;

    assign strobe = i_pi_read || i_pi_write;

    always_ff @(posedge i_sys) begin
        if (i_reset) begin
            state       <= st_idle;
            o_pi_rvalid <= 1'b0;
        end else begin
            o_pi_rvalid <= 1'b0;
            case (state)
                st_idle: begin
                    if (strobe) begin
                        state <= addr_q.mem.region ? st_done : st_req;
                    end
                end
                st_req: begin
                    if (i_mem_ack) begin
                        state <= st_release;
                    end
                end
                st_release: begin
                    if (!i_mem_ack) begin
                        state <= st_done;
                    end
                end
                default: begin
                    state       <= st_idle;
                    o_pi_rvalid <= !is_write;
                end
            endcase
        end
    end

    always_ff @(posedge i_sys) begin
        if (state == st_idle && strobe) begin
            is_write <= i_pi_write;
            is_reg   <= addr_q.mem.region;
            wdata_q  <= i_pi_ad;
        end
        if (state == st_req && i_mem_ack && !is_write) begin
            o_pi_rdata <= i_mem_rsp.rdata;
        end
        if (state == st_done) begin
            if (is_reg && !is_write) begin
                o_pi_rdata <= i_reg_rdata;
            end
            // bursts walk forward one word per access.
            addr_q.mem.word <= addr_q.mem.word + 1'b1;
        end
        // a new address latch takes precedence over the increment.
        if (i_pi_aleh) begin
            addr_q[31:16] <= i_pi_ad;
        end
        if (i_pi_alel) begin
            addr_q[15:0] <= i_pi_ad;
        end
    end

    assign o_pi_busy = (state != st_idle);
    assign o_mem_req = (state == st_req);

    always_comb begin
        o_mem.addr  = addr_q.mem.word;
        o_mem.wdata = wdata_q;
        o_mem.write = is_write;
        o_reg.valid = (state == st_done) && is_reg;
        o_reg.write = is_write;
        o_reg.idx   = addr_q.regs.idx;
        o_reg.wdata = wdata_q;
    end

    // the console must wait for busy to fall before the next strobe.
    a_no_strobe_busy: assert property (@(posedge i_sys) disable iff (i_reset)
        o_pi_busy |-> !strobe);

endmodule

// File: cart_top.sv
`timescale 1ns/1ps

module cart_top (
    input  logic                i_sys,
    input  logic                i_reset,
    input  logic                i_pi_aleh,
    input  logic                i_pi_alel,
    input  logic                i_pi_read,
    input  logic                i_pi_write,
    input  logic [15:0]         i_pi_ad,
    output logic [15:0]         o_pi_rdata,
    output logic                o_pi_rvalid,
    output logic                o_pi_busy,
    input  logic                i_host_req,
    input  cart_pkg::host_cmd_t i_host_cmd,
    output logic                o_host_ack,
    output logic                o_n64_irq,
    output logic                o_led
);

    logic               console_req;
    logic               console_ack;
    cart_pkg::mem_req_t console_mem;
    cart_pkg::mem_rsp_t console_rsp;
    logic               host_req;
    logic               host_ack;
    cart_pkg::mem_req_t host_mem;
    cart_pkg::reg_bus_t reg_bus;
    logic [15:0]        reg_rdata;
    logic               notify;
    logic               loader_busy;
    logic               store_en;
    cart_pkg::mem_req_t store_req;
    logic [15:0]        store_rdata;

    pi_frontend u_pi_frontend (
        .i_sys       (i_sys),
        .i_reset     (i_reset),
        .i_pi_aleh   (i_pi_aleh),
        .i_pi_alel   (i_pi_alel),
        .i_pi_read   (i_pi_read),
        .i_pi_write  (i_pi_write),
        .i_pi_ad     (i_pi_ad),
        .o_pi_rdata  (o_pi_rdata),
        .o_pi_rvalid (o_pi_rvalid),
        .o_pi_busy   (o_pi_busy),
        .o_mem_req   (console_req),
        .o_mem       (console_mem),
        .i_mem_ack   (console_ack),
        .i_mem_rsp   (console_rsp),
        .o_reg       (reg_bus),
        .i_reg_rdata (reg_rdata)
    );

    cfg_regs u_cfg_regs (
        .i_sys         (i_sys),
        .i_reset       (i_reset),
        .i_reg         (reg_bus),
        .o_reg_rdata   (reg_rdata),
        .i_notify      (notify),
        .i_loader_busy (loader_busy),
        .o_n64_irq     (o_n64_irq),
        .o_led         (o_led)
    );

    host_loader u_host_loader (
        .i_sys      (i_sys),
        .i_reset    (i_reset),
        .i_host_req (i_host_req),
        .i_host_cmd (i_host_cmd),
        .o_host_ack (o_host_ack),
        .o_mem_req  (host_req),
        .o_mem      (host_mem),
        .i_mem_ack  (host_ack),
        .o_notify   (notify),
        .o_busy     (loader_busy)
    );

    // the host only writes, so its read response is left open.
    mem_arbiter u_mem_arbiter (
        .i_sys         (i_sys),
        .i_reset       (i_reset),
        .i_req_a       (console_req),
        .i_mem_a       (console_mem),
        .o_ack_a       (console_ack),
        .o_rsp_a       (console_rsp),
        .i_req_b       (host_req),
        .i_mem_b       (host_mem),
        .o_ack_b       (host_ack),
        .o_rsp_b       (),
        .o_store_en    (store_en),
        .o_store       (store_req),
        .i_store_rdata (store_rdata)
    );

    cart_store u_cart_store (
        .i_sys      (i_sys),
        .i_store_en (store_en),
        .i_store    (store_req),
        .o_rdata    (store_rdata)
    );

endmodule

// File: tb_cart_top.sv
`timescale 1ns/1ps
`include "cart_settings.svh"

module tb_cart_top;

    // each test's length in bus operations, which sets the watchdog limit.
    localparam int TEST_LENGTHS    = 2 + 18 + 18 + 10 + 24 + 70;
    localparam int WATCHDOG_CYCLES = TEST_LENGTHS * 40;

    logic                sys;
    logic                reset;
    logic                pi_aleh;
    logic                pi_alel;
    logic                pi_read;
    logic                pi_write;
    logic [15:0]         pi_ad;
    logic [15:0]         pi_rdata;
    logic                pi_rvalid;
    logic                pi_busy;
    logic                host_req;
    cart_pkg::host_cmd_t host_cmd;
    logic                host_ack;
    logic                n64_irq;
    logic                led;

    logic [15:0] shadow [2**`CART_ADDR_W];
    logic [15:0] host_words [16];
    logic [15:0] console_words [16];
    logic        sh_pending;
    logic        sh_enable;
    logic        sh_led;
    logic [15:0] sh_scratch;
    logic [15:0] lfsr_q;
    int          errors;
    int          tests_run;
    int          tests_passed;

    cart_top DUT (
        .i_sys       (sys),
        .i_reset     (reset),
        .i_pi_aleh   (pi_aleh),
        .i_pi_alel   (pi_alel),
        .i_pi_read   (pi_read),
        .i_pi_write  (pi_write),
        .i_pi_ad     (pi_ad),
        .o_pi_rdata  (pi_rdata),
        .o_pi_rvalid (pi_rvalid),
        .o_pi_busy   (pi_busy),
        .i_host_req  (host_req),
        .i_host_cmd  (host_cmd),
        .o_host_ack  (host_ack),
        .o_n64_irq   (n64_irq),
        .o_led       (led)
    );

    initial begin
        sys = 1'b0;
        forever #5 sys = ~sys;
    end

    initial begin
        repeat (WATCHDOG_CYCLES + 10) @(posedge sys);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    a_rvalid_pulse: assert property (@(posedge sys) disable iff (reset)
        pi_rvalid |=> !pi_rvalid)
        else begin
            errors++;
            $display("read valid stayed high for more than one cycle at %0t", $time);
        end

    a_rvalid_idle: assert property (@(posedge sys) disable iff (reset)
        pi_rvalid |-> !pi_busy)
        else begin
            errors++;
            $display("read valid came while the front end was still busy at %0t", $time);
        end

    a_ack_after_req: assert property (@(posedge sys) disable iff (reset)
        $rose(host_ack) |-> host_req)
        else begin
            errors++;
            $display("host ack rose without a pending request at %0t", $time);
        end

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] r;
        r = 16'h0000;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r      = {r[14:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] mem_addr(input logic [`CART_ADDR_W-1:0] word);
        return {1'b0, {(31-`CART_ADDR_W){1'b0}}, word};
    endfunction

    function automatic logic [31:0] reg_addr(input logic [1:0] idx);
        return {1'b1, 29'd0, idx};
    endfunction

    // status bit 1 reads zero because the loader is idle during register checks.
    function automatic logic [15:0] expected_reg(input logic [1:0] idx);
        case (idx)
            2'd0:    return {14'd0, 1'b0, sh_pending};
            2'd1:    return {14'd0, sh_led, sh_enable};
            2'd2:    return sh_scratch;
            default: return 16'h0000;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected)
        else begin
            errors++;
            $display("Fail %s expected 0x%04h actual 0x%04h", name, expected, actual);
        end
    endtask

    task automatic check_pins();
        check_value("o_led", {15'd0, sh_led}, {15'd0, led});
        check_value("o_n64_irq", {15'd0, sh_pending && sh_enable}, {15'd0, n64_irq});
    endtask

    task automatic pi_set_addr(input logic [31:0] addr);
        @(posedge sys);
        pi_aleh <= 1'b1;
        pi_ad   <= addr[31:16];
        @(posedge sys);
        pi_aleh <= 1'b0;
        pi_alel <= 1'b1;
        pi_ad   <= addr[15:0];
        @(posedge sys);
        pi_alel <= 1'b0;
    endtask

    task automatic pi_read_word(output logic [15:0] data, output int cycles);
        @(posedge sys);
        pi_read <= 1'b1;
        @(posedge sys);
        pi_read <= 1'b0;
        cycles = 0;
        do begin
            @(negedge sys);
            cycles++;
        end while (!pi_rvalid);
        data = pi_rdata;
    endtask

    task automatic pi_write_word(input logic [15:0] data);
        @(posedge sys);
        pi_write <= 1'b1;
        pi_ad    <= data;
        @(posedge sys);
        pi_write <= 1'b0;
        do begin
            @(negedge sys);
        end while (pi_busy);
    endtask

    task automatic host_command(input cart_pkg::host_op_e op, input logic [15:0] payload);
        @(posedge sys);
        host_req         <= 1'b1;
        host_cmd.op      <= op;
        host_cmd.payload <= payload;
        do begin
            @(negedge sys);
        end while (!host_ack);
        @(posedge sys);
        host_req <= 1'b0;
        do begin
            @(negedge sys);
        end while (host_ack);
    endtask

    task automatic host_notify();
        host_command(cart_pkg::notify, 16'h0000);
        sh_pending = 1'b1;
    endtask

    task automatic reg_write(input logic [1:0] idx, input logic [15:0] data);
        pi_set_addr(reg_addr(idx));
        pi_write_word(data);
        if (idx == 2'd0 && data[0]) begin
            sh_pending = 1'b0;
        end else if (idx == 2'd1) begin
            sh_enable = data[0];
            sh_led    = data[1];
        end else if (idx == 2'd2) begin
            sh_scratch = data;
        end
    endtask

    task automatic reg_check(input logic [1:0] idx);
        logic [15:0] data;
        int          cycles;
        pi_set_addr(reg_addr(idx));
        pi_read_word(data, cycles);
        check_value($sformatf("o_pi_rdata reg %0d", idx), expected_reg(idx), data);
        assert (cycles == 2)
        else begin
            errors++;
            $display("register read took %0d cycles instead of 2", cycles);
        end
    endtask

    task automatic fill_words(input int count);
        for (int k = 0; k < count; k++) begin
            host_words[k]    = random_bits(16);
            console_words[k] = random_bits(16);
        end
    endtask

    task automatic host_write_burst(input logic [`CART_ADDR_W-1:0] base, input int count);
        logic [`CART_ADDR_W-1:0] word;
        word = base;
        host_command(cart_pkg::set_addr, {{(16-`CART_ADDR_W){1'b0}}, base});
        for (int k = 0; k < count; k++) begin
            host_command(cart_pkg::write_data, host_words[k]);
            shadow[word] = host_words[k];
            word         = word + 1'b1;
        end
    endtask

    task automatic console_write_burst(input logic [`CART_ADDR_W-1:0] base, input int count);
        logic [`CART_ADDR_W-1:0] word;
        word = base;
        pi_set_addr(mem_addr(base));
        for (int k = 0; k < count; k++) begin
            pi_write_word(console_words[k]);
            shadow[word] = console_words[k];
            word         = word + 1'b1;
        end
    endtask

    task automatic console_read_burst(input logic [`CART_ADDR_W-1:0] base, input int count);
        logic [`CART_ADDR_W-1:0] word;
        logic [15:0]             data;
        int                      cycles;
        word = base;
        pi_set_addr(mem_addr(base));
        for (int k = 0; k < count; k++) begin
            pi_read_word(data, cycles);
            check_value($sformatf("o_pi_rdata word 0x%03h", word), shadow[word], data);
            word = word + 1'b1;
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    initial begin
        int                      errors_before;
        logic [15:0]             data;
        logic [`CART_ADDR_W-1:0] host_base;
        logic [`CART_ADDR_W-1:0] console_base;
        reset        = 1'b1;
        pi_aleh      = 1'b0;
        pi_alel      = 1'b0;
        pi_read      = 1'b0;
        pi_write     = 1'b0;
        pi_ad        = 16'h0000;
        host_req     = 1'b0;
        host_cmd     = '0;
        sh_pending   = 1'b0;
        sh_enable    = 1'b0;
        sh_led       = 1'b0;
        sh_scratch   = 16'h0000;
        lfsr_q       = 16'd49;
        errors       = 0;
        tests_run    = 0;
        tests_passed = 0;
        repeat (10) @(posedge sys);
        reset <= 1'b0;
        @(negedge sys);

        errors_before = errors;
        check_value("o_pi_busy", 16'h0000, {15'd0, pi_busy});
        check_value("o_pi_rvalid", 16'h0000, {15'd0, pi_rvalid});
        check_value("o_host_ack", 16'h0000, {15'd0, host_ack});
        check_pins();
        reg_check(2'd0);
        end_test("reset state", errors_before);

        errors_before = errors;
        fill_words(8);
        data      = random_bits(8);
        host_base = data[`CART_ADDR_W-1:0];
        host_write_burst(host_base, 8);
        console_read_burst(host_base, 8);
        end_test("host load then console burst read", errors_before);

        errors_before = errors;
        fill_words(8);
        data         = random_bits(8);
        console_base = 10'd256 + data[`CART_ADDR_W-1:0];
        console_write_burst(console_base, 8);
        console_read_burst(console_base, 8);
        end_test("console burst write and read-back", errors_before);

        errors_before = errors;
        reg_write(2'd1, 16'h0002);
        check_pins();
        reg_write(2'd2, random_bits(16));
        reg_check(2'd2);
        reg_check(2'd3);
        reg_check(2'd1);
        end_test("led, scratch and register 3", errors_before);

        errors_before = errors;
        reg_write(2'd1, {14'd0, sh_led, 1'b1});
        host_notify();
        check_pins();
        reg_check(2'd0);
        reg_write(2'd0, 16'h0001);
        check_pins();
        reg_write(2'd1, {14'd0, sh_led, 1'b0});
        host_notify();
        check_pins();
        reg_check(2'd0);
        reg_write(2'd1, {14'd0, sh_led, 1'b1});
        check_pins();
        reg_write(2'd0, 16'h0001);
        check_pins();
        end_test("interrupt pending and enable", errors_before);

        // the two ranges never overlap, so the shadow writes cannot collide.
        errors_before = errors;
        fill_words(16);
        data         = random_bits(7);
        host_base    = 10'd512 + data[`CART_ADDR_W-1:0];
        data         = random_bits(7);
        console_base = 10'd768 + data[`CART_ADDR_W-1:0];
        fork
            host_write_burst(host_base, 16);
            console_write_burst(console_base, 16);
        join
        console_read_burst(host_base, 16);
        console_read_burst(console_base, 16);
        end_test("concurrent host and console writes", errors_before);

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: cart_top.f
+incdir+.
cart_pkg.sv
cart_store.sv
mem_arbiter.sv
cfg_regs.sv
host_loader.sv
pi_frontend.sv
cart_top.sv
tb_cart_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -eo pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_cart_top \
    -f cart_top.f \
    -o Vtb_cart_top

./obj_dir/Vtb_cart_top | tee "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

echo "simulation finished without failures"
